//--- source/axil_iob_pkg.sv
`default_nettype none

package axil_iob_pkg;

   // decoded IOb target
   typedef enum logic {
      SEL_RAM  = 1'b0,
      SEL_REGS = 1'b1
   } slave_sel_e;

   // register block access state, one wait state before ready
   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_ACK  = 1'b1
   } regs_state_e;

   // word offsets in the register block, offset 3 unused
   typedef enum logic [1:0] {
      REG_SCRATCH = 2'd0,
      REG_ACC     = 2'd1,
      REG_ACC_CLR = 2'd2
   } reg_offset_e;

   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- source/iob_if.sv
`timescale 1ns/1ps
`default_nettype none

// IOb native bus, one request at a time
interface iob_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);
   logic                  valid;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_W-1:0]     wdata;
   logic [DATA_W/8-1:0]   wstrb;
   logic                  ready;
   logic                  rvalid;
   logic [DATA_W-1:0]     rdata;

   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rvalid, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rvalid, rdata
   );
endinterface

`default_nettype wire

//--- source/axil_iob_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axil_iob_bridge #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire [ADDR_W-1:0]     axil_awaddr,
   input  wire                  axil_awvalid,
   output logic                 axil_awready,
   input  wire [DATA_W-1:0]     axil_wdata,
   input  wire [DATA_W/8-1:0]   axil_wstrb,
   input  wire                  axil_wvalid,
   output logic                 axil_wready,
   output logic                 axil_bvalid,
   output logic [1:0]           axil_bresp,
   input  wire [ADDR_W-1:0]     axil_araddr,
   input  wire                  axil_arvalid,
   output logic                 axil_arready,
   output logic                 axil_rvalid,
   output logic [DATA_W-1:0]    axil_rdata,
   output logic [1:0]           axil_rresp,
   iob_if.master                iob
);

   logic              awvalid_q;
   logic [ADDR_W-1:0] awaddr_q;
   logic              arvalid_q;
   logic [ADDR_W-1:0] araddr_q;
   logic [ADDR_W-1:0] addr_q;
   logic [ADDR_W-1:0] addr_nxt;

   // all AXI channels share the single IOb ready
   assign axil_awready = iob.ready;
   assign axil_wready  = iob.ready;
   assign axil_arready = iob.ready;

   // write response pulses in the accept cycle
   assign axil_bvalid = axil_wvalid & iob.ready;
   assign axil_bresp  = axil_iob_pkg::RESP_OKAY;

   assign axil_rvalid = iob.rvalid;
   assign axil_rdata  = iob.rdata;
   assign axil_rresp  = axil_iob_pkg::RESP_OKAY;

   // one request, write before read
   assign iob.valid = axil_wvalid | axil_arvalid;
   assign iob.wdata = axil_wdata;
   // zero strobes mark a read
   assign iob.wstrb = axil_wvalid ? axil_wstrb : '0;

   // registered address paths
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         awvalid_q <= 1'b0;
         arvalid_q <= 1'b0;
         awaddr_q  <= '0;
         araddr_q  <= '0;
         addr_q    <= '0;
      end else begin
         awvalid_q <= axil_awvalid;
         arvalid_q <= axil_arvalid;
         if (axil_awvalid) awaddr_q <= axil_awaddr;
         if (axil_arvalid) araddr_q <= axil_araddr;
         addr_q <= addr_nxt;
      end
   end

   // keep the last seen address for idle cycles
   always_comb begin
      if (awvalid_q)
         addr_nxt = awaddr_q;
      else if (arvalid_q)
         addr_nxt = araddr_q;
      else
         addr_nxt = addr_q;
   end

   always_comb begin
      if (axil_awvalid)
         iob.addr = axil_awaddr;
      else if (axil_arvalid)
         iob.addr = axil_araddr;
      else
         iob.addr = addr_q;
   end

   // write address and data arrive together
   a_aw_with_w: assert property (@(posedge clk) disable iff (!arst_n)
      axil_awvalid |-> axil_wvalid);

   // master issues one transaction at a time
   a_no_wr_rd: assert property (@(posedge clk) disable iff (!arst_n)
      !(axil_wvalid && axil_arvalid));

endmodule

`default_nettype wire

//--- source/iob_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module iob_addr_decode #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int RAM_ADDR_W = 8
) (
   input  wire   clk,
   input  wire   arst_n,
   iob_if.slave  host,
   iob_if.master ram,
   iob_if.master regs
);

   logic [ADDR_W-1:0]        addr;
   axil_iob_pkg::slave_sel_e sel;
   axil_iob_pkg::slave_sel_e rd_sel_q;
   logic [DATA_W-1:0]        rdata;

   assign addr = host.addr;
   assign sel  = addr[RAM_ADDR_W+2] ? axil_iob_pkg::SEL_REGS : axil_iob_pkg::SEL_RAM;

   // request fans out, valid goes to one target only
   assign ram.valid  = host.valid & (sel == axil_iob_pkg::SEL_RAM);
   assign ram.addr   = addr;
   assign ram.wdata  = host.wdata;
   assign ram.wstrb  = host.wstrb;
   assign regs.valid = host.valid & (sel == axil_iob_pkg::SEL_REGS);
   assign regs.addr  = addr;
   assign regs.wdata = host.wdata;
   assign regs.wstrb = host.wstrb;

   assign host.ready = (sel == axil_iob_pkg::SEL_REGS) ? regs.ready : ram.ready;

   // remember who owns the read in flight
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         rd_sel_q <= axil_iob_pkg::SEL_RAM;
      else if (host.valid && host.ready && host.wstrb == '0)
         rd_sel_q <= sel;
   end

   assign rdata       = (rd_sel_q == axil_iob_pkg::SEL_REGS) ? regs.rdata : ram.rdata;
   assign host.rdata  = rdata;
   assign host.rvalid = (rd_sel_q == axil_iob_pkg::SEL_REGS) ? regs.rvalid : ram.rvalid;

   a_one_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
      !(ram.rvalid && regs.rvalid));

endmodule

`default_nettype wire

//--- source/iob_ram.sv
`timescale 1ns/1ps
`default_nettype none

module iob_ram #(
   parameter int DATA_W     = 32,
   parameter int RAM_ADDR_W = 8
) (
   input  wire  clk,
   input  wire  arst_n,
   iob_if.slave bus
);

   localparam int DEPTH = 2 ** RAM_ADDR_W;

   logic [DATA_W-1:0]     mem [DEPTH];
   logic [RAM_ADDR_W-1:0] word;
   logic [DATA_W-1:0]     rdata_q;
   logic                  rvalid_q;

   // word address, byte offset dropped
   assign word = bus.addr[RAM_ADDR_W+1:2];

   assign bus.ready  = 1'b1;
   assign bus.rdata  = rdata_q;
   assign bus.rvalid = rvalid_q;

   always_ff @(posedge clk) begin
      if (bus.valid) begin
         for (int i = 0; i < DATA_W / 8; i++) begin
            if (bus.wstrb[i]) mem[word][8*i +: 8] <= bus.wdata[8*i +: 8];
         end
         if (bus.wstrb == '0) rdata_q <= mem[word];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         rvalid_q <= 1'b0;
      else
         rvalid_q <= bus.valid & bus.ready & (bus.wstrb == '0);
   end

endmodule

`default_nettype wire

//--- source/iob_regs.sv
`timescale 1ns/1ps
`default_nettype none

module iob_regs #(
   parameter int DATA_W = 32
) (
   input  wire  clk,
   input  wire  arst_n,
   iob_if.slave bus
);

   axil_iob_pkg::regs_state_e state;
   axil_iob_pkg::reg_offset_e offset;
   logic                      accept;
   logic [DATA_W-1:0]         scratch;
   logic [DATA_W-1:0]         acc;
   logic [DATA_W-1:0]         cnt;
   logic [DATA_W-1:0]         rdata_q;
   logic                      rvalid_q;

   assign offset     = axil_iob_pkg::reg_offset_e'(bus.addr[3:2]);
   assign bus.ready  = (state == axil_iob_pkg::ST_ACK);
   assign accept     = bus.valid & bus.ready;
   assign bus.rdata  = rdata_q;
   assign bus.rvalid = rvalid_q;

   // idle sees valid, ack accepts next cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         state <= axil_iob_pkg::ST_IDLE;
      else if (state == axil_iob_pkg::ST_IDLE && bus.valid)
         state <= axil_iob_pkg::ST_ACK;
      else if (accept)
         state <= axil_iob_pkg::ST_IDLE;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scratch  <= '0;
         acc      <= '0;
         cnt      <= '0;
         rdata_q  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept & (bus.wstrb == '0);
         if (accept && bus.wstrb != '0) begin
            case (offset)
               axil_iob_pkg::REG_SCRATCH: begin
                  for (int i = 0; i < DATA_W / 8; i++) begin
                     if (bus.wstrb[i]) scratch[8*i +: 8] <= bus.wdata[8*i +: 8];
                  end
               end
               axil_iob_pkg::REG_ACC: begin
                  acc <= acc + bus.wdata;
                  cnt <= cnt + 1'b1;
               end
               axil_iob_pkg::REG_ACC_CLR: begin
                  acc <= '0;
                  cnt <= '0;
               end
               default: ;
            endcase
         end else if (accept) begin
            case (offset)
               axil_iob_pkg::REG_SCRATCH: rdata_q <= scratch;
               axil_iob_pkg::REG_ACC:     rdata_q <= acc;
               // clear offset reads back the add count
               axil_iob_pkg::REG_ACC_CLR: rdata_q <= cnt;
               default:                   rdata_q <= '0;
            endcase
         end
      end
   end

   // master holds the request through the wait state
   a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
      bus.valid && !bus.ready |=> bus.valid && $stable(bus.addr) && $stable(bus.wstrb));

endmodule

`default_nettype wire

//--- source/axil_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_periph_top #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int RAM_ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire [ADDR_W-1:0]     axil_awaddr,
   input  wire                  axil_awvalid,
   output logic                 axil_awready,
   input  wire [DATA_W-1:0]     axil_wdata,
   input  wire [DATA_W/8-1:0]   axil_wstrb,
   input  wire                  axil_wvalid,
   output logic                 axil_wready,
   output logic                 axil_bvalid,
   output logic [1:0]           axil_bresp,
   input  wire [ADDR_W-1:0]     axil_araddr,
   input  wire                  axil_arvalid,
   output logic                 axil_arready,
   output logic                 axil_rvalid,
   output logic [DATA_W-1:0]    axil_rdata,
   output logic [1:0]           axil_rresp
);

   iob_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) cpu_bus ();
   iob_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) ram_bus ();
   iob_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) reg_bus ();

   axil_iob_bridge #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_bridge (
      .clk          (clk),
      .arst_n       (arst_n),
      .axil_awaddr  (axil_awaddr),
      .axil_awvalid (axil_awvalid),
      .axil_awready (axil_awready),
      .axil_wdata   (axil_wdata),
      .axil_wstrb   (axil_wstrb),
      .axil_wvalid  (axil_wvalid),
      .axil_wready  (axil_wready),
      .axil_bvalid  (axil_bvalid),
      .axil_bresp   (axil_bresp),
      .axil_araddr  (axil_araddr),
      .axil_arvalid (axil_arvalid),
      .axil_arready (axil_arready),
      .axil_rvalid  (axil_rvalid),
      .axil_rdata   (axil_rdata),
      .axil_rresp   (axil_rresp),
      .iob          (cpu_bus.master)
   );

   iob_addr_decode #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .RAM_ADDR_W(RAM_ADDR_W)) u_decode (
      .clk    (clk),
      .arst_n (arst_n),
      .host   (cpu_bus.slave),
      .ram    (ram_bus.master),
      .regs   (reg_bus.master)
   );

   iob_ram #(.DATA_W(DATA_W), .RAM_ADDR_W(RAM_ADDR_W)) u_ram (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (ram_bus.slave)
   );

   iob_regs #(.DATA_W(DATA_W)) u_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (reg_bus.slave)
   );

endmodule

`default_nettype wire

//--- verif/axil_periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_periph_tb;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int RAM_ADDR_W = 8;
   localparam int CLK_PERIOD = 8;
   localparam int WAIT_MAX   = 16;
   // reset read, ram fill, strobes, accumulator, mixed, isolation
   localparam int NUM_TXN    = 1 + 2 * 64 + 2 * 24 + 16 + 17 + 13;
   localparam logic [ADDR_W-1:0] REG_BASE = ADDR_W'(1) << (RAM_ADDR_W + 2);

   logic                clk;
   logic                arst_n;
   logic [ADDR_W-1:0]   axil_awaddr;
   logic                axil_awvalid;
   logic                axil_awready;
   logic [DATA_W-1:0]   axil_wdata;
   logic [DATA_W/8-1:0] axil_wstrb;
   logic                axil_wvalid;
   logic                axil_wready;
   logic                axil_bvalid;
   logic [1:0]          axil_bresp;
   logic [ADDR_W-1:0]   axil_araddr;
   logic                axil_arvalid;
   logic                axil_arready;
   logic                axil_rvalid;
   logic [DATA_W-1:0]   axil_rdata;
   logic [1:0]          axil_rresp;

   // expected state of the peripherals
   logic [DATA_W-1:0] ram_m [2 ** RAM_ADDR_W];
   logic [DATA_W-1:0] scratch_m;
   logic [DATA_W-1:0] sum_m;
   logic [DATA_W-1:0] cnt_m;
   logic [DATA_W-1:0] exp_q [$];
   logic [ADDR_W-1:0] ram_addrs [64];
   logic [31:0]       lfsr;
   int                errors;
   int                reads_seen;

   axil_periph_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .RAM_ADDR_W(RAM_ADDR_W)) dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_d,
         input logic [DATA_W-1:0] new_d, input logic [DATA_W/8-1:0] strb);
      logic [DATA_W-1:0] r;
      r = old_d;
      for (int i = 0; i < DATA_W / 8; i++) begin
         if (strb[i]) r[8*i +: 8] = new_d[8*i +: 8];
      end
      return r;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input logic [1:0] off);
      return REG_BASE + ADDR_W'(off) * 4;
   endfunction

   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
      if (!addr[RAM_ADDR_W+2]) return ram_m[addr[RAM_ADDR_W+1:2]];
      case (addr[3:2])
         axil_iob_pkg::REG_SCRATCH: return scratch_m;
         axil_iob_pkg::REG_ACC:     return sum_m;
         axil_iob_pkg::REG_ACC_CLR: return cnt_m;
         default:                   return '0;
      endcase
   endfunction

   function automatic void model_write(input logic [ADDR_W-1:0] addr,
         input logic [DATA_W-1:0] data, input logic [DATA_W/8-1:0] strb);
      if (!addr[RAM_ADDR_W+2]) begin
         ram_m[addr[RAM_ADDR_W+1:2]] = merge_bytes(ram_m[addr[RAM_ADDR_W+1:2]], data, strb);
      end else begin
         case (addr[3:2])
            axil_iob_pkg::REG_SCRATCH: scratch_m = merge_bytes(scratch_m, data, strb);
            axil_iob_pkg::REG_ACC: begin
               sum_m = sum_m + data;
               cnt_m = cnt_m + 1;
            end
            axil_iob_pkg::REG_ACC_CLR: begin
               sum_m = '0;
               cnt_m = '0;
            end
            default: ;
         endcase
      end
   endfunction

   // called on a falling edge, returns on a falling edge
   task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
         input logic [DATA_W/8-1:0] strb);
      int waits;
      waits        = 0;
      axil_arvalid = 1'b0;
      axil_awaddr  = addr;
      axil_wdata   = data;
      axil_wstrb   = strb;
      axil_awvalid = 1'b1;
      axil_wvalid  = 1'b1;
      @(posedge clk);
      while (!axil_awready && waits < WAIT_MAX) begin
         waits++;
         @(posedge clk);
      end
      if (!axil_awready) begin
         $display("write to 0x%h was never accepted", addr);
         errors++;
      end else begin
         // register block adds one wait state
         assert (waits == (addr[RAM_ADDR_W+2] ? 1 : 0)) else begin
            $display("CHECK FAILED axil_awready wait 0x%h addr 0x%h", waits, addr);
            errors++;
         end
         assert (axil_bvalid && axil_wready && axil_bresp == axil_iob_pkg::RESP_OKAY) else begin
            $display("CHECK FAILED axil_bvalid 0x%h axil_wready 0x%h axil_bresp 0x%h addr 0x%h",
                     axil_bvalid, axil_wready, axil_bresp, addr);
            errors++;
         end
         model_write(addr, data, strb);
      end
      @(negedge clk);
      axil_awvalid = 1'b0;
      axil_wvalid  = 1'b0;
   endtask

   task automatic axil_read(input logic [ADDR_W-1:0] addr);
      int waits;
      waits        = 0;
      axil_araddr  = addr;
      axil_arvalid = 1'b1;
      exp_q.push_back(ref_read(addr));
      @(posedge clk);
      while (!axil_arready && waits < WAIT_MAX) begin
         waits++;
         @(posedge clk);
      end
      if (!axil_arready) begin
         $display("read of 0x%h was never accepted", addr);
         errors++;
      end else begin
         assert (waits == (addr[RAM_ADDR_W+2] ? 1 : 0)) else begin
            $display("CHECK FAILED axil_arready wait 0x%h addr 0x%h", waits, addr);
            errors++;
         end
      end
      @(negedge clk);
      axil_arvalid = 1'b0;
      waits        = 0;
      @(posedge clk);
      while (!axil_rvalid && waits < WAIT_MAX) begin
         waits++;
         @(posedge clk);
      end
      if (!axil_rvalid) begin
         $display("no read data returned for 0x%h", addr);
         errors++;
      end else begin
         // data follows one cycle after acceptance
         assert (waits == 0) else begin
            $display("CHECK FAILED axil_rvalid wait 0x%h addr 0x%h", waits, addr);
            errors++;
         end
      end
      @(negedge clk);
   endtask

   // compare each returned word with the oldest expected value
   always @(posedge clk) begin : compare
      logic [DATA_W-1:0] expected;
      if (arst_n && axil_rvalid) begin
         reads_seen++;
         if (exp_q.size() == 0) begin
            $display("read data returned with no read outstanding");
            errors++;
         end else begin
            expected = exp_q.pop_front();
            assert (axil_rdata == expected) else begin
               $display("CHECK FAILED axil_rdata got 0x%h exp 0x%h", axil_rdata, expected);
               errors++;
            end
            assert (axil_rresp == axil_iob_pkg::RESP_OKAY) else begin
               $display("CHECK FAILED axil_rresp got 0x%h exp 0x%h", axil_rresp,
                        axil_iob_pkg::RESP_OKAY);
               errors++;
            end
         end
      end
   end

   initial begin
      #(CLK_PERIOD * (3 + 200 * NUM_TXN));
      $display("watchdog expired before the test sequence ended, %0d errors", errors);
      $display("Checks failed");
      $finish;
   end

   initial begin : stimulus
      logic [DATA_W/8-1:0] strb;
      logic [ADDR_W-1:0]   addr;
      clk          = 1'b0;
      arst_n       = 1'b0;
      axil_awaddr  = '0;
      axil_awvalid = 1'b0;
      axil_wdata   = '0;
      axil_wstrb   = '0;
      axil_wvalid  = 1'b0;
      axil_araddr  = '0;
      axil_arvalid = 1'b0;
      lfsr         = 32'h94d7_b77b;
      scratch_m    = '0;
      sum_m        = '0;
      cnt_m        = '0;
      errors       = 0;
      reads_seen   = 0;
      repeat (3) begin
         @(posedge clk);
         assert (!axil_bvalid && !axil_rvalid) else begin
            $display("CHECK FAILED axil_bvalid 0x%h axil_rvalid 0x%h in reset",
                     axil_bvalid, axil_rvalid);
            errors++;
         end
      end
      @(negedge clk);
      arst_n = 1'b1;

      axil_read(reg_addr(axil_iob_pkg::REG_SCRATCH));

      for (int i = 0; i < 64; i++) begin
         ram_addrs[i] = rand_bits(RAM_ADDR_W) << 2;
         axil_write(ram_addrs[i], rand_bits(DATA_W), '1);
      end
      for (int i = 0; i < 64; i++) axil_read(ram_addrs[i]);

      // partial strobes, zero strobes would turn into a read
      for (int i = 0; i < 24; i++) begin
         strb = (DATA_W / 8)'(rand_bits(DATA_W / 8));
         if (strb == '0) strb = 4'b1001;
         addr = (i < 16) ? ram_addrs[i] : reg_addr(axil_iob_pkg::REG_SCRATCH);
         axil_write(addr, rand_bits(DATA_W), strb);
         axil_read(addr);
      end

      axil_write(reg_addr(axil_iob_pkg::REG_ACC_CLR), '0, '1);
      for (int i = 0; i < 10; i++) axil_write(reg_addr(axil_iob_pkg::REG_ACC), rand_bits(32), '1);
      axil_read(reg_addr(axil_iob_pkg::REG_ACC));
      axil_read(reg_addr(axil_iob_pkg::REG_ACC_CLR));
      axil_write(reg_addr(axil_iob_pkg::REG_ACC_CLR), rand_bits(DATA_W), '1);
      axil_read(reg_addr(axil_iob_pkg::REG_ACC));
      axil_read(reg_addr(axil_iob_pkg::REG_ACC_CLR));

      // mixed accesses with no idle cycle between them
      for (int i = 0; i < 16; i++) begin
         case (rand_bits(2))
            0: axil_write(reg_addr(axil_iob_pkg::REG_ACC), rand_bits(DATA_W), '1);
            1: axil_read(reg_addr(axil_iob_pkg::REG_ACC));
            2: axil_read(ram_addrs[i]);
            default: axil_write(reg_addr(axil_iob_pkg::REG_SCRATCH), rand_bits(DATA_W), '1);
         endcase
      end
      axil_read(reg_addr(axil_iob_pkg::REG_ACC_CLR));

      // same low address bits on both sides of the decoder
      for (int i = 0; i < 4; i++) axil_write(ADDR_W'(i * 4), rand_bits(DATA_W), '1);
      for (int i = 0; i < 4; i++) axil_write(reg_addr(2'(i)), rand_bits(DATA_W), '1);
      for (int i = 0; i < 4; i++) axil_read(ADDR_W'(i * 4));
      axil_read(reg_addr(2'd3));

      repeat (4) @(negedge clk);
      assert (exp_q.size() == 0) else begin
         $display("%0d reads never returned data", exp_q.size());
         errors++;
      end
      $display("errors: %0d, reads compared: %0d", errors, reads_seen);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
source/axil_iob_pkg.sv
source/iob_if.sv
source/axil_iob_bridge.sv
source/iob_addr_decode.sv
source/iob_ram.sv
source/iob_regs.sv
source/axil_periph_top.sv
verif/axil_periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AXI-Lite peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module axil_periph_tb -o axil_periph_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/axil_periph_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
   exit 0
fi
exit 1
